// File: logic/blake_defines.svh
/* BLAKE-256 core constants */

`ifndef BLAKE_DEFINES_SVH
`define BLAKE_DEFINES_SVH

`define BLAKE_W          32

// BLAKE-256 constants, leading digits of pi
`define BLAKE_C0         32'h243F6A88
`define BLAKE_C1         32'h85A308D3
`define BLAKE_C2         32'h13198A2E
`define BLAKE_C3         32'h03707344
`define BLAKE_C4         32'hA4093822
`define BLAKE_C5         32'h299F31D0
`define BLAKE_C6         32'h082EFA98
`define BLAKE_C7         32'hEC4E6C89
`define BLAKE_C8         32'h452821E6
`define BLAKE_C9         32'h38D01377
`define BLAKE_C10        32'hBE5466CF
`define BLAKE_C11        32'h34E90C6C
`define BLAKE_C12        32'hC0AC29B7
`define BLAKE_C13        32'hC97C50DD
`define BLAKE_C14        32'h3F84D5B5
`define BLAKE_C15        32'hB5470917

`define BLAKE_ROUNDS     8
`define BLAKE_STEPS      16

// 80-byte header, 640 message bits
`define BLAKE_T          32'h00000280

// fixed padding of the second block
`define BLAKE_PAD_M4     32'h80000000
`define BLAKE_PAD_M13    32'h00000001
`define BLAKE_PAD_M15    32'h00000280

// midstate plus m0..m2
`define BLAKE_LOAD_BITS  352

`endif

// File: logic/blake_pkg.sv
/* BLAKE miner types */

`include "blake_defines.svh"

package blake_pkg;

   typedef logic [`BLAKE_W-1:0] word_t;

   // v0 in the low word
   typedef word_t [15:0] state_t;
   typedef word_t [7:0]  chain_t;
   typedef word_t [2:0]  hdr_msg_t;

   // [k][0] feeds the first half-step of G unit k, [k][1] the second
   typedef word_t [3:0][1:0] lane_msg_t;

   typedef enum logic [1:0] {
      CTRL_IDLE,
      CTRL_RUN,
      CTRL_CAPTURE,
      CTRL_ACK
   } ctrl_state_t;

endpackage

// File: logic/header_loader.sv
/* serial header loader */

`timescale 1ns/1ps

`include "blake_defines.svh"

module header_loader
   import blake_pkg::*;
(
   input  logic     clk,
   input  logic     shift_en_i,
   input  logic     din_i,
   output chain_t   midstate_o,
   output hdr_msg_t hdr_msg_o
);

   // midstate in the upper 256 bits, m2..m0 below
   logic [`BLAKE_LOAD_BITS-1:0] shift_q;

   // bits enter at the bottom, msb of the message moves into the midstate
   always_ff @(posedge clk) begin
      if (shift_en_i) begin
         shift_q <= {shift_q[`BLAKE_LOAD_BITS-2:0], din_i};
      end
   end

   assign midstate_o = shift_q[`BLAKE_LOAD_BITS-1 -: 256];
   assign hdr_msg_o  = shift_q[95:0];

endmodule

// File: logic/msg_schedule.sv
/* BLAKE-256 message schedule */

`timescale 1ns/1ps

`include "blake_defines.svh"

module msg_schedule
   import blake_pkg::*;
(
   input  logic [2:0] round_i,
   input  logic       diag_i,
   input  hdr_msg_t   hdr_msg_i,
   input  word_t      nonce_i,
   output lane_msg_t  lane_msg_o
);

   // sigma rows 0..7, one nibble per entry, entry 0 in the top nibble
   localparam logic [63:0] SIGMA [`BLAKE_ROUNDS] = '{
      64'h0123456789abcdef,
      64'hea489fd61c02b753,
      64'hb8c052fdae367194,
      64'h7931dcbe265a40f8,
      64'h905724afe1bc683d,
      64'h2c6a0b834d75fe19,
      64'hc51fed4a0763928b,
      64'hdb7ec13950f4862a
   };

   localparam word_t CONST [16] = '{
      `BLAKE_C0,  `BLAKE_C1,  `BLAKE_C2,  `BLAKE_C3,
      `BLAKE_C4,  `BLAKE_C5,  `BLAKE_C6,  `BLAKE_C7,
      `BLAKE_C8,  `BLAKE_C9,  `BLAKE_C10, `BLAKE_C11,
      `BLAKE_C12, `BLAKE_C13, `BLAKE_C14, `BLAKE_C15
   };

   function automatic logic [3:0] sigma(input logic [2:0] r, input logic [3:0] pos);
      return SIGMA[r][63 - 4*pos -: 4];
   endfunction

   word_t      msg [16];
   logic [3:0] sel_e [4];
   logic [3:0] sel_o [4];

   // second block of the header, only m3 changes per nonce
   always_comb begin
      msg     = '{default: '0};
      msg[0]  = hdr_msg_i[0];
      msg[1]  = hdr_msg_i[1];
      msg[2]  = hdr_msg_i[2];
      msg[3]  = nonce_i;
      msg[4]  = `BLAKE_PAD_M4;
      msg[13] = `BLAKE_PAD_M13;
      msg[15] = `BLAKE_PAD_M15;
   end

   // G unit j = diag*4 + k reads sigma entries 2j and 2j+1
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         sel_e[k]         = sigma(round_i, {diag_i, 2'(k), 1'b0});
         sel_o[k]         = sigma(round_i, {diag_i, 2'(k), 1'b1});
         lane_msg_o[k][0] = msg[sel_e[k]] ^ CONST[sel_o[k]];
         lane_msg_o[k][1] = msg[sel_o[k]] ^ CONST[sel_e[k]];
      end
   end

endmodule

// File: logic/g_function.sv
/* BLAKE-256 G function */

`timescale 1ns/1ps

module g_function
   import blake_pkg::*;
(
   input  word_t a_i,
   input  word_t b_i,
   input  word_t c_i,
   input  word_t d_i,
   input  word_t msg_i,
   input  word_t msg_ip_i,
   output word_t a_o,
   output word_t b_o,
   output word_t c_o,
   output word_t d_o
);

   function automatic word_t rotr(input word_t x, input int n);
      return (x >> n) | (x << (32 - n));
   endfunction

   word_t a1, b1, c1, d1;

   // first half
   assign a1 = a_i + b_i + msg_i;
   assign d1 = rotr(d_i ^ a1, 16);
   assign c1 = c_i + d1;
   assign b1 = rotr(b_i ^ c1, 12);

   // second half
   assign a_o = a1 + b1 + msg_ip_i;
   assign d_o = rotr(d1 ^ a_o, 8);
   assign c_o = c1 + d_o;
   assign b_o = rotr(b1 ^ c_o, 7);

endmodule

// File: logic/round_state.sv
/* BLAKE-256 working state */

`timescale 1ns/1ps

`include "blake_defines.svh"

module round_state
   import blake_pkg::*;
(
   input  logic      clk,
   input  logic      load_i,
   input  logic      step_en_i,
   input  logic      diag_i,
   input  chain_t    midstate_i,
   input  word_t     nonce_i,
   input  lane_msg_t lane_msg_i,
   output state_t    state_o,
   output word_t     nonce_o
);

   state_t v_q;
   state_t v_init;
   state_t v_next;
   word_t  nonce_q;

   wire word_t g_a [4];
   wire word_t g_b [4];
   wire word_t g_c [4];
   wire word_t g_d [4];

   // salt is zero, t1 is zero
   assign v_init = {`BLAKE_C7, `BLAKE_C6,
                    `BLAKE_C5 ^ `BLAKE_T, `BLAKE_C4 ^ `BLAKE_T,
                    `BLAKE_C3, `BLAKE_C2, `BLAKE_C1, `BLAKE_C0,
                    midstate_i};

   // columns (k, 4+k, 8+k, 12+k), diagonals rotate rows b, c, d by 1, 2, 3
   for (genvar k = 0; k < 4; k++) begin : g_unit
      localparam int BD = 4 + (k + 1) % 4;
      localparam int CD = 8 + (k + 2) % 4;
      localparam int DD = 12 + (k + 3) % 4;

      g_function u_g (
         .a_i      (v_q[k]),
         .b_i      (diag_i ? v_q[BD] : v_q[4 + k]),
         .c_i      (diag_i ? v_q[CD] : v_q[8 + k]),
         .d_i      (diag_i ? v_q[DD] : v_q[12 + k]),
         .msg_i    (lane_msg_i[k][0]),
         .msg_ip_i (lane_msg_i[k][1]),
         .a_o      (g_a[k]),
         .b_o      (g_b[k]),
         .c_o      (g_c[k]),
         .d_o      (g_d[k])
      );
   end

   // write results back to the words they came from
   always_comb begin
      v_next = v_q;
      for (int k = 0; k < 4; k++) begin
         v_next[k] = g_a[k];
         if (diag_i) begin
            v_next[4 + (k + 1) % 4]  = g_b[k];
            v_next[8 + (k + 2) % 4]  = g_c[k];
            v_next[12 + (k + 3) % 4] = g_d[k];
         end else begin
            v_next[4 + k]  = g_b[k];
            v_next[8 + k]  = g_c[k];
            v_next[12 + k] = g_d[k];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_i) begin
         v_q     <= v_init;
         nonce_q <= nonce_i;
      end else if (step_en_i) begin
         v_q <= v_next;
      end
   end

   assign state_o = v_q;
   assign nonce_o = nonce_q;

endmodule

// File: logic/hash_control.sv
/* compression sequencer */

`timescale 1ns/1ps

`include "blake_defines.svh"

module hash_control
   import blake_pkg::*;
(
   input  logic       clk,
   input  logic       reset_i,
   input  logic       req_i,
   input  logic       shift_i,
   output logic       ack_o,
   output logic       busy_o,
   output logic       shift_en_o,
   output logic       load_o,
   output logic       step_en_o,
   output logic       diag_o,
   output logic       capture_o,
   output logic [2:0] round_o
);

   localparam int CNT_W = $clog2(`BLAKE_STEPS);
   localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(`BLAKE_STEPS - 1);

   ctrl_state_t      state_q;
   logic [CNT_W-1:0] step_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= CTRL_IDLE;
         step_q  <= '0;
      end else begin
         case (state_q)
            CTRL_IDLE: begin
               if (req_i) begin
                  state_q <= CTRL_RUN;
                  step_q  <= '0;
               end
            end
            CTRL_RUN: begin
               step_q <= step_q + 1'b1;
               if (step_q == STEP_LAST) begin
                  state_q <= CTRL_CAPTURE;
               end
            end
            CTRL_CAPTURE: state_q <= CTRL_ACK;
            // hold until the requester drops req
            CTRL_ACK: begin
               if (!req_i) begin
                  state_q <= CTRL_IDLE;
               end
            end
            default: state_q <= CTRL_IDLE;
         endcase
      end
   end

   assign load_o     = (state_q == CTRL_IDLE) && req_i;
   assign shift_en_o = (state_q == CTRL_IDLE) && shift_i;
   assign step_en_o  = (state_q == CTRL_RUN);
   assign capture_o  = (state_q == CTRL_CAPTURE);
   assign ack_o      = (state_q == CTRL_ACK);
   assign busy_o     = (state_q != CTRL_IDLE);

   // column step on even counts
   assign round_o = step_q[CNT_W-1:1];
   assign diag_o  = step_q[0];

endmodule

// File: logic/digest_final.sv
/* digest finalization */

`timescale 1ns/1ps

module digest_final
   import blake_pkg::*;
(
   input  logic   clk,
   input  logic   reset_i,
   input  logic   capture_i,
   input  chain_t midstate_i,
   input  state_t state_i,
   output chain_t digest_o,
   output logic   match_o
);

   chain_t digest_next;

   // h'i = hi ^ vi ^ v(i+8), no salt
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         digest_next[i] = midstate_i[i] ^ state_i[i] ^ state_i[i + 8];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         digest_o <= '0;
         match_o  <= 1'b0;
      end else if (capture_i) begin
         digest_o <= digest_next;
         match_o  <= (digest_next[7] == '0);
      end
   end

endmodule

// File: logic/blake_miner_core.sv
/* BLAKE-256 miner core */

`timescale 1ns/1ps

module blake_miner_core
   import blake_pkg::*;
(
   input  logic   clk,
   input  logic   reset_i,
   input  logic   shift_i,
   input  logic   din_i,
   input  logic   req_i,
   input  word_t  nonce_i,
   output logic   ack_o,
   output logic   busy_o,
   output logic   match_o,
   output chain_t digest_o
);

   logic       shift_en;
   logic       load;
   logic       step_en;
   logic       diag;
   logic       capture;
   logic [2:0] round_idx;

   chain_t    midstate;
   hdr_msg_t  hdr_msg;
   lane_msg_t lane_msg;
   state_t    state;
   word_t     nonce_q;

   header_loader u_loader (
      .clk        (clk),
      .shift_en_i (shift_en),
      .din_i      (din_i),
      .midstate_o (midstate),
      .hdr_msg_o  (hdr_msg)
   );

   hash_control u_control (
      .clk        (clk),
      .reset_i    (reset_i),
      .req_i      (req_i),
      .shift_i    (shift_i),
      .ack_o      (ack_o),
      .busy_o     (busy_o),
      .shift_en_o (shift_en),
      .load_o     (load),
      .step_en_o  (step_en),
      .diag_o     (diag),
      .capture_o  (capture),
      .round_o    (round_idx)
   );

   // nonce comes from the copy taken at load
   msg_schedule u_schedule (
      .round_i    (round_idx),
      .diag_i     (diag),
      .hdr_msg_i  (hdr_msg),
      .nonce_i    (nonce_q),
      .lane_msg_o (lane_msg)
   );

   round_state u_state (
      .clk        (clk),
      .load_i     (load),
      .step_en_i  (step_en),
      .diag_i     (diag),
      .midstate_i (midstate),
      .nonce_i    (nonce_i),
      .lane_msg_i (lane_msg),
      .state_o    (state),
      .nonce_o    (nonce_q)
   );

   digest_final u_final (
      .clk        (clk),
      .reset_i    (reset_i),
      .capture_i  (capture),
      .midstate_i (midstate),
      .state_i    (state),
      .digest_o   (digest_o),
      .match_o    (match_o)
   );

endmodule

// File: verification/tb_clock.sv
/* testbench clock */

`timescale 1ns/1ps

module tb_clock #(
   parameter int HALF_PERIOD_NS = 10
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

// File: verification/blake_miner_chk.sv
/* miner core assertions */

`timescale 1ns/1ps

module blake_miner_chk
   import blake_pkg::*;
(
   input logic     clk,
   input logic     reset_i,
   input logic     req_i,
   input logic     ack_i,
   input logic     busy_i,
   input logic     match_i,
   input chain_t   digest_i,
   input chain_t   exp_digest_i,
   input chain_t   midstate_i,
   input hdr_msg_t hdr_msg_i
);

   int err_cnt = 0;

   a_reset: assert property (@(posedge clk)
      reset_i |=> !ack_i && !busy_i && !match_i && digest_i == '0)
      else begin $error("outputs not cleared by reset"); err_cnt++; end

   a_idle: assert property (@(posedge clk) disable iff (reset_i)
      !busy_i && !req_i |=> !busy_i && !ack_i)
      else begin $error("core left idle without a request"); err_cnt++; end

   // load edge, 16 steps, capture
   a_ack_time: assert property (@(posedge clk) disable iff (reset_i)
      $rose(busy_i) |-> (busy_i && !ack_i) [*17] ##1 (ack_i && busy_i))
      else begin
         $error("ack_o did not rise 18 cycles after the request or busy_o fell early");
         err_cnt++;
      end

   a_ack_hold: assert property (@(posedge clk) disable iff (reset_i)
      ack_i && req_i |=> ack_i && busy_i)
      else begin $error("ack_o or busy_o dropped while req_i was high"); err_cnt++; end

   a_ack_drop: assert property (@(posedge clk) disable iff (reset_i)
      ack_i && !req_i |=> !ack_i && !busy_i)
      else begin
         $error("ack_o or busy_o still high one cycle after req_i fell");
         err_cnt++;
      end

   a_digest: assert property (@(posedge clk) disable iff (reset_i)
      $rose(ack_i) |-> digest_i == exp_digest_i)
      else begin
         $error("[ERROR] digest_o expected %h actual %h", $sampled(exp_digest_i),
                $sampled(digest_i));
         err_cnt++;
      end

   a_digest_stable: assert property (@(posedge clk) disable iff (reset_i)
      ack_i ##1 ack_i |-> $stable(digest_i))
      else begin $error("digest_o changed while ack_o was high"); err_cnt++; end

   a_match: assert property (@(posedge clk) disable iff (reset_i)
      ack_i |-> match_i == (digest_i[7] == '0))
      else begin
         $error("[ERROR] match_o expected %h actual %h", $sampled(digest_i[7] == '0),
                $sampled(match_i));
         err_cnt++;
      end

   // loader frozen during a compression
   a_loader: assert property (@(posedge clk) disable iff (reset_i)
      busy_i |=> $stable(midstate_i) && $stable(hdr_msg_i))
      else begin $error("header loader shifted while the core was busy"); err_cnt++; end

endmodule

// File: verification/blake_model.svh
/* reference BLAKE-256 compression */

`ifndef BLAKE_MODEL_SVH
`define BLAKE_MODEL_SVH

`include "blake_defines.svh"

// sigma rows for the first eight rounds
localparam int MODEL_SIGMA [8][16] = '{
   '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
   '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
   '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
   '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
   '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
   '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
   '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
   '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10}
};

localparam logic [31:0] MODEL_C [16] = '{
   `BLAKE_C0,  `BLAKE_C1,  `BLAKE_C2,  `BLAKE_C3,
   `BLAKE_C4,  `BLAKE_C5,  `BLAKE_C6,  `BLAKE_C7,
   `BLAKE_C8,  `BLAKE_C9,  `BLAKE_C10, `BLAKE_C11,
   `BLAKE_C12, `BLAKE_C13, `BLAKE_C14, `BLAKE_C15
};

// four columns, then four diagonals
localparam int MODEL_G_IDX [8][4] = '{
   '{0, 4,  8, 12}, '{1, 5,  9, 13}, '{2, 6, 10, 14}, '{3, 7, 11, 15},
   '{0, 5, 10, 15}, '{1, 6, 11, 12}, '{2, 7,  8, 13}, '{3, 4,  9, 14}
};

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
   logic [63:0] dbl;
   dbl = {x, x} >> n;
   return dbl[31:0];
endfunction

task automatic compute_expected(input chain_t ms, input hdr_msg_t hm, input word_t n,
                                output chain_t dig);
   logic [31:0] m [16];
   logic [31:0] v [16];
   int          a;
   int          b;
   int          c;
   int          d;
   int          s0;
   int          s1;
   m = '{default: 32'h0};
   m[0] = hm[0];
   m[1] = hm[1];
   m[2] = hm[2];
   m[3] = n;
   m[4] = `BLAKE_PAD_M4;
   m[13] = `BLAKE_PAD_M13;
   m[15] = `BLAKE_PAD_M15;
   for (int i = 0; i < 8; i++) begin
      v[i] = ms[i];
      v[i + 8] = MODEL_C[i];
   end
   v[12] = v[12] ^ `BLAKE_T;
   v[13] = v[13] ^ `BLAKE_T;
   for (int r = 0; r < `BLAKE_ROUNDS; r++) begin
      for (int g = 0; g < 8; g++) begin
         a = MODEL_G_IDX[g][0];
         b = MODEL_G_IDX[g][1];
         c = MODEL_G_IDX[g][2];
         d = MODEL_G_IDX[g][3];
         s0 = MODEL_SIGMA[r][2 * g];
         s1 = MODEL_SIGMA[r][2 * g + 1];
         v[a] = v[a] + v[b] + (m[s0] ^ MODEL_C[s1]);
         v[d] = ror32(v[d] ^ v[a], 16);
         v[c] = v[c] + v[d];
         v[b] = ror32(v[b] ^ v[c], 12);
         v[a] = v[a] + v[b] + (m[s1] ^ MODEL_C[s0]);
         v[d] = ror32(v[d] ^ v[a], 8);
         v[c] = v[c] + v[d];
         v[b] = ror32(v[b] ^ v[c], 7);
      end
   end
   for (int i = 0; i < 8; i++) begin
      dig[i] = ms[i] ^ v[i] ^ v[i + 8];
   end
endtask

`endif

// File: verification/tb_blake_miner.sv
/* BLAKE miner core testbench */

`timescale 1ns/1ps

`include "blake_defines.svh"

module tb_blake_miner
   import blake_pkg::*;
();

   localparam int N_KAT = 4;
   localparam int N_TESTS = N_KAT + 2;
   localparam int WATCHDOG_CYCLES = N_TESTS * (`BLAKE_LOAD_BITS + 40);

   logic   clk;
   logic   reset;
   logic   shift;
   logic   din;
   logic   req;
   word_t  nonce;
   logic   ack;
   logic   busy;
   logic   match;
   chain_t digest;
   chain_t exp_digest;
   int     seed;
   int     tests_run;
   int     tests_failed;

   `include "blake_model.svh"

   tb_clock #(.HALF_PERIOD_NS(10)) u_clock (.clk_o(clk));

   blake_miner_core blake_miner_core_inst (
      .clk      (clk),
      .reset_i  (reset),
      .shift_i  (shift),
      .din_i    (din),
      .req_i    (req),
      .nonce_i  (nonce),
      .ack_o    (ack),
      .busy_o   (busy),
      .match_o  (match),
      .digest_o (digest)
   );

   bind blake_miner_core blake_miner_chk chk_inst (
      .clk          (clk),
      .reset_i      (reset_i),
      .req_i        (req_i),
      .ack_i        (ack_o),
      .busy_i       (busy_o),
      .match_i      (match_o),
      .digest_i     (digest_o),
      .exp_digest_i (tb_blake_miner.exp_digest),
      .midstate_i   (midstate),
      .hdr_msg_i    (hdr_msg)
   );

   task automatic random_header(output chain_t ms, output hdr_msg_t hm);
      for (int i = 0; i < 8; i++) begin
         ms[i] = $random(seed);
      end
      for (int i = 0; i < 3; i++) begin
         hm[i] = $random(seed);
      end
   endtask

   // midstate first, msb first
   task automatic load_header(input chain_t ms, input hdr_msg_t hm);
      logic [`BLAKE_LOAD_BITS-1:0] bits;
      bits = {ms, hm};
      for (int i = `BLAKE_LOAD_BITS - 1; i >= 0; i--) begin
         shift = 1'b1;
         din = bits[i];
         @(posedge clk);
         #2;
      end
      shift = 1'b0;
   endtask

   task automatic run_request(input word_t n, input int hold, input bit disturb);
      nonce = n;
      req = 1'b1;
      @(posedge clk);
      #2;
      do begin
         if (disturb) begin
            shift = $random(seed);
            din = $random(seed);
            nonce = $random(seed);
         end
         @(posedge clk);
         #2;
      end while (!ack);
      repeat (hold) begin
         if (disturb) begin
            shift = $random(seed);
            din = $random(seed);
         end
         @(posedge clk);
         #2;
      end
      shift = 1'b0;
      req = 1'b0;
      while (ack) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      int new_errs;
      new_errs = blake_miner_core_inst.chk_inst.err_cnt - errs_before;
      tests_run++;
      if (new_errs != 0) begin
         tests_failed++;
         $display("test %0d %s: %0d assertion failures", tests_run, name, new_errs);
      end else begin
         $display("test %0d %s: ok", tests_run, name);
      end
   endtask

   initial begin
      chain_t   ms;
      hdr_msg_t hm;
      word_t    n0;
      int       errs_before;
      seed = 86;
      tests_run = 0;
      tests_failed = 0;
      reset = 1'b1;
      shift = 1'b0;
      din = 1'b0;
      req = 1'b0;
      nonce = '0;
      exp_digest = '0;
      errs_before = blake_miner_core_inst.chk_inst.err_cnt;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;

      repeat (5) @(posedge clk);
      #2;
      finish_test("reset and idle", errs_before);

      // hold req a few extra cycles to stretch the ack phase
      for (int t = 0; t < N_KAT; t++) begin
         errs_before = blake_miner_core_inst.chk_inst.err_cnt;
         random_header(ms, hm);
         n0 = $random(seed);
         load_header(ms, hm);
         compute_expected(ms, hm, n0, exp_digest);
         run_request(n0, t, 1'b0);
         finish_test($sformatf("known answer %0d", t), errs_before);
      end

      errs_before = blake_miner_core_inst.chk_inst.err_cnt;
      random_header(ms, hm);
      n0 = $random(seed);
      load_header(ms, hm);
      compute_expected(ms, hm, n0, exp_digest);
      run_request(n0, 1, 1'b1);
      // same header, fresh nonce
      n0 = $random(seed);
      compute_expected(ms, hm, n0, exp_digest);
      run_request(n0, 0, 1'b0);
      finish_test("shift while busy", errs_before);

      repeat (3) @(posedge clk);
      $display("%0d tests run, %0d failed, %0d assertion failures", tests_run,
               tests_failed, blake_miner_core_inst.chk_inst.err_cnt);
      if (tests_failed == 0 && blake_miner_core_inst.chk_inst.err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 20);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: tb.f
+incdir+logic
+incdir+verification
logic/blake_pkg.sv
logic/header_loader.sv
logic/msg_schedule.sv
logic/g_function.sv
logic/round_state.sv
logic/hash_control.sv
logic/digest_final.sv
logic/blake_miner_core.sv
verification/tb_clock.sv
verification/blake_miner_chk.sv
verification/tb_blake_miner.sv
